//--- source/fdam_pkg.sv
package fdam_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fixed widths.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int ADDR_WIDTH = 32;
  localparam int QTD_WIDTH = 16;
  localparam int LINE_WIDTH = 64;
  localparam int TAG_WIDTH = 8;
  localparam int CONF_TYPE_WIDTH = 2;
  localparam int CONF_WIDTH = ADDR_WIDTH + QTD_WIDTH + TAG_WIDTH;

  // Lines fetched per read request.
  localparam int BURST_LINES = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [QTD_WIDTH-1:0] qtd_t;
  typedef logic [LINE_WIDTH-1:0] line_t;
  typedef logic [TAG_WIDTH-1:0] tag_t;
  typedef logic [CONF_TYPE_WIDTH-1:0] conf_type_t;
  typedef logic [CONF_WIDTH-1:0] conf_word_t;

  // Configuration type codes.
  localparam conf_type_t CONF_TYPE_NONE = 2'd0;
  localparam conf_type_t CONF_TYPE_IN = 2'd1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Configuration word layout.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address on top, then line count, queue id in the low bits.
  localparam int CONF_ID_LSB = 0;
  localparam int CONF_QTD_LSB = CONF_ID_LSB + TAG_WIDTH;
  localparam int CONF_ADDR_LSB = CONF_QTD_LSB + QTD_WIDTH;

endpackage

//--- source/fdam_conf_receiver.sv
`timescale 1ns/1ns

module fdam_conf_receiver
  import fdam_pkg::*;
#(
  parameter int ID_QUEUE = 0
) (
  input  logic       clk,
  input  logic       rst_internal,
  input  conf_type_t conf_valid,
  input  conf_word_t conf,
  output logic       conf_ready,
  output addr_t      addr_base,
  output qtd_t       qtd_lines
);

  tag_t conf_id;
  logic conf_match;

  assign conf_id = conf[CONF_ID_LSB +: TAG_WIDTH];

  // Only input-queue words aimed at this queue.
  assign conf_match = (conf_valid == CONF_TYPE_IN) && (conf_id == tag_t'(ID_QUEUE));

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      conf_ready <= 1'b0;
    end else if (conf_match) begin
      conf_ready <= 1'b1;
    end
  end

  // A later match overwrites the payload fields.
  always_ff @(posedge clk) begin
    if (conf_match) begin
      addr_base <= conf[CONF_ADDR_LSB +: ADDR_WIDTH];
      qtd_lines <= conf[CONF_QTD_LSB +: QTD_WIDTH];
    end
  end

endmodule

//--- source/fdam_line_fifo.sv
`timescale 1ns/1ns

module fdam_line_fifo
  import fdam_pkg::*;
#(
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic                     clk,
  input  logic                     rst_internal,
  input  logic                     we,
  input  line_t                    din,
  input  logic                     re,
  output line_t                    dout,
  output logic                     valid,
  output logic                     empty,
  output logic [FIFO_DEPTH_BITS:0] count
);

  localparam int DEPTH = 1 << FIFO_DEPTH_BITS;

  line_t mem [DEPTH];
  logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic do_read;

  assign empty = (count == '0);
  assign do_read = re && !empty;

  // Storage and read register.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_ptr] <= din;
    end
    if (do_read) begin
      dout <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      valid <= 1'b0;
    end else begin
      valid <= do_read;
      if (we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({we, do_read})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- source/fdam_input_queue_controller.sv
`timescale 1ns/1ns

module fdam_input_queue_controller
  import fdam_pkg::*;
#(
  parameter int ID_QUEUE = 0,
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic       clk,
  input  logic       rst_internal,
  input  logic       start,
  input  conf_type_t conf_valid,
  input  conf_word_t conf,
  output logic       req_valid,
  output addr_t      req_addr,
  input  logic       grant,
  input  logic       rsp_valid,
  input  tag_t       rsp_tag,
  input  line_t      rsp_data,
  output logic       user_available,
  input  logic       user_rd_req,
  output line_t      user_rd_data,
  output logic       user_rd_valid,
  output logic       done
);

  localparam int CNT_W = QTD_WIDTH + 1;
  localparam logic [FIFO_DEPTH_BITS:0] FIFO_DEPTH = (FIFO_DEPTH_BITS + 1)'(1 << FIFO_DEPTH_BITS);
  localparam logic [FIFO_DEPTH_BITS:0] CREDIT_BURST = (FIFO_DEPTH_BITS + 1)'(BURST_LINES);

  typedef enum logic {
    IDLE,
    ISSUE
  } state_t;

  state_t state;
  logic conf_ready;
  addr_t addr_base;
  qtd_t qtd_lines;
  addr_t addr_next;
  logic [CNT_W-1:0] req_lines;
  logic [CNT_W-1:0] rcv_lines;
  logic [FIFO_DEPTH_BITS:0] credits;
  logic pop;
  logic rsp_match;
  logic fifo_we;
  line_t fifo_din;
  line_t fifo_dout;
  logic fifo_valid;
  logic fifo_empty;

  fdam_conf_receiver #(
    .ID_QUEUE(ID_QUEUE)
  ) u_conf_receiver (
    .clk(clk),
    .rst_internal(rst_internal),
    .conf_valid(conf_valid),
    .conf(conf),
    .conf_ready(conf_ready),
    .addr_base(addr_base),
    .qtd_lines(qtd_lines)
  );

  fdam_line_fifo #(
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) u_line_fifo (
    .clk(clk),
    .rst_internal(rst_internal),
    .we(fifo_we),
    .din(fifo_din),
    .re(pop),
    .dout(fifo_dout),
    .valid(fifo_valid),
    .empty(fifo_empty),
    .count()
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign req_valid = (state == ISSUE) && start && (req_lines < CNT_W'(qtd_lines))
                     && (credits >= CREDIT_BURST);
  assign req_addr = addr_next;

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      state <= IDLE;
      addr_next <= '0;
      req_lines <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (conf_ready) begin
            addr_next <= addr_base;
            state <= ISSUE;
          end
        end
        ISSUE: begin
          if (grant) begin
            addr_next <= addr_next + ADDR_WIDTH'(BURST_LINES);
            req_lines <= req_lines + CNT_W'(BURST_LINES);
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // One credit per free FIFO slot, taken per burst and returned per pop.
  always_ff @(posedge clk) begin
    if (rst_internal) begin
      credits <= FIFO_DEPTH;
    end else begin
      credits <= credits - (grant ? CREDIT_BURST : '0) + (pop ? 1'b1 : 1'b0);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response and user side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rsp_match = rsp_valid && (rsp_tag == tag_t'(ID_QUEUE));
  assign user_available = !fifo_empty;
  assign pop = user_rd_req && user_available;

  always_ff @(posedge clk) begin
    fifo_din <= rsp_data;
    user_rd_data <= fifo_dout;
  end

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      fifo_we <= 1'b0;
      rcv_lines <= '0;
      user_rd_valid <= 1'b0;
      done <= 1'b0;
    end else begin
      fifo_we <= rsp_match;
      user_rd_valid <= fifo_valid;
      if (rsp_match) begin
        rcv_lines <= rcv_lines + 1'b1;
      end
      // Sticky until reset.
      if (start && conf_ready && (rcv_lines >= CNT_W'(qtd_lines))) begin
        done <= 1'b1;
      end
    end
  end

endmodule

//--- source/fdam_read_arbiter.sv
`timescale 1ns/1ns

module fdam_read_arbiter
  import fdam_pkg::*;
#(
  parameter int NUM_QUEUES = 2
) (
  input  logic                  clk,
  input  logic                  rst_internal,
  input  logic [NUM_QUEUES-1:0] req_valid,
  input  addr_t [NUM_QUEUES-1:0] req_addr,
  input  logic                  mem_ready,
  output logic [NUM_QUEUES-1:0] grant,
  output logic                  mem_req_valid,
  output addr_t                 mem_req_addr,
  output tag_t                  mem_req_tag
);

  localparam int IDX_W = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;

  logic [IDX_W-1:0] last_winner;
  logic [IDX_W-1:0] winner;
  logic found;
  logic accept;

  // First requester after the last winner.
  always_comb begin : pick
    int idx;
    found = 1'b0;
    winner = last_winner;
    for (int ofs = 1; ofs <= NUM_QUEUES; ofs++) begin
      idx = (int'(last_winner) + ofs) % NUM_QUEUES;
      if (!found && req_valid[idx]) begin
        found = 1'b1;
        winner = IDX_W'(idx);
      end
    end
  end

  assign accept = found && mem_ready;
  assign mem_req_valid = accept;
  assign mem_req_addr = req_addr[winner];
  assign mem_req_tag = tag_t'(winner);
  assign grant = accept ? (NUM_QUEUES'(1) << winner) : '0;

  // Queue 0 wins first out of reset.
  always_ff @(posedge clk) begin
    if (rst_internal) begin
      last_winner <= IDX_W'(NUM_QUEUES - 1);
    end else if (accept) begin
      last_winner <= winner;
    end
  end

endmodule

//--- source/fdam_input_subsystem.sv
`timescale 1ns/1ns

module fdam_input_subsystem
  import fdam_pkg::*;
#(
  parameter int NUM_QUEUES = 2,
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic       clk,
  input  logic       rst_internal,
  input  logic       start,
  input  conf_type_t conf_valid,
  input  conf_word_t conf,
  output logic       mem_req_valid,
  output addr_t      mem_req_addr,
  output tag_t       mem_req_tag,
  input  logic       mem_ready,
  input  logic       mem_rsp_valid,
  input  tag_t       mem_rsp_tag,
  input  line_t      mem_rsp_data,
  output logic       user_available_0,
  input  logic       user_rd_req_0,
  output line_t      user_rd_data_0,
  output logic       user_rd_valid_0,
  output logic       done_0,
  output logic       user_available_1,
  input  logic       user_rd_req_1,
  output line_t      user_rd_data_1,
  output logic       user_rd_valid_1,
  output logic       done_1
);

  logic [NUM_QUEUES-1:0] req_valid;
  addr_t [NUM_QUEUES-1:0] req_addr;
  logic [NUM_QUEUES-1:0] grant;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Queue controllers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  fdam_input_queue_controller #(
    .ID_QUEUE(0),
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) u_queue_0 (
    .clk(clk),
    .rst_internal(rst_internal),
    .start(start),
    .conf_valid(conf_valid),
    .conf(conf),
    .req_valid(req_valid[0]),
    .req_addr(req_addr[0]),
    .grant(grant[0]),
    .rsp_valid(mem_rsp_valid),
    .rsp_tag(mem_rsp_tag),
    .rsp_data(mem_rsp_data),
    .user_available(user_available_0),
    .user_rd_req(user_rd_req_0),
    .user_rd_data(user_rd_data_0),
    .user_rd_valid(user_rd_valid_0),
    .done(done_0)
  );

  fdam_input_queue_controller #(
    .ID_QUEUE(1),
    .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
  ) u_queue_1 (
    .clk(clk),
    .rst_internal(rst_internal),
    .start(start),
    .conf_valid(conf_valid),
    .conf(conf),
    .req_valid(req_valid[1]),
    .req_addr(req_addr[1]),
    .grant(grant[1]),
    .rsp_valid(mem_rsp_valid),
    .rsp_tag(mem_rsp_tag),
    .rsp_data(mem_rsp_data),
    .user_available(user_available_1),
    .user_rd_req(user_rd_req_1),
    .user_rd_data(user_rd_data_1),
    .user_rd_valid(user_rd_valid_1),
    .done(done_1)
  );

  // Shared memory read port.
  fdam_read_arbiter #(
    .NUM_QUEUES(NUM_QUEUES)
  ) u_read_arbiter (
    .clk(clk),
    .rst_internal(rst_internal),
    .req_valid(req_valid),
    .req_addr(req_addr),
    .mem_ready(mem_ready),
    .grant(grant),
    .mem_req_valid(mem_req_valid),
    .mem_req_addr(mem_req_addr),
    .mem_req_tag(mem_req_tag)
  );

endmodule

//--- bench/fdam_mem_model.sv
`timescale 1ns/1ns

module fdam_mem_model
  import fdam_pkg::*;
(
  input  logic       clk,
  input  logic       rst_internal,
  input  logic [7:0] stall_pct,
  input  logic [7:0] stall_len,
  input  logic       mem_req_valid,
  input  addr_t      mem_req_addr,
  input  tag_t       mem_req_tag,
  output logic       mem_ready,
  output logic       mem_rsp_valid,
  output tag_t       mem_rsp_tag,
  output line_t      mem_rsp_data
);

  addr_t pend_addr [$];
  tag_t pend_tag [$];
  int pend_due [$];
  int cycle = 0;
  int beat = 0;
  int stall_left = 0;

  // Line contents are scrambled from the full address.
  function automatic line_t line_pattern(input addr_t addr);
    return {addr ^ 32'hc3a5_5a3c, addr * 32'h9e37_79b1};
  endfunction

  initial begin
    mem_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_tag = '0;
    mem_rsp_data = '0;
  end

  // Accepted requests wait 2 to 10 cycles and are served in arrival order.
  always @(posedge clk) begin
    if (!rst_internal && mem_req_valid && mem_ready) begin
      pend_addr.push_back(mem_req_addr);
      pend_tag.push_back(mem_req_tag);
      pend_due.push_back(cycle + 2 + int'($urandom_range(8)));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Ready and beats change on the falling edge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin
    cycle++;
    if (rst_internal) begin
      pend_addr.delete();
      pend_tag.delete();
      pend_due.delete();
      beat = 0;
      stall_left = 0;
      mem_ready = 1'b0;
      mem_rsp_valid = 1'b0;
    end else begin
      if (stall_left > 0) begin
        stall_left--;
        mem_ready = 1'b0;
      end else if ($urandom_range(99) < stall_pct) begin
        stall_left = int'($urandom_range(stall_len, 1)) - 1;
        mem_ready = 1'b0;
      end else begin
        mem_ready = 1'b1;
      end
      mem_rsp_valid = 1'b0;
      if (pend_due.size() > 0 && cycle >= pend_due[0]) begin
        mem_rsp_valid = 1'b1;
        mem_rsp_tag = pend_tag[0];
        mem_rsp_data = line_pattern(pend_addr[0] + addr_t'(beat));
        beat++;
        if (beat == BURST_LINES) begin
          beat = 0;
          void'(pend_addr.pop_front());
          void'(pend_tag.pop_front());
          void'(pend_due.pop_front());
        end
      end
    end
  end

endmodule

//--- bench/tb_fdam_input_subsystem.sv
`timescale 1ns/1ns

module tb_fdam_input_subsystem
  import fdam_pkg::*;
();

  localparam int SEED = 32'h7ac1_83a1;
  localparam int RESET_CYCLES = 10;
  localparam int FIFO_LINES = 16;
  localparam int WORST_LATENCY = 40;
  localparam int MARGIN = 4;

  logic clk;
  logic rst_internal;
  logic start;
  conf_type_t conf_valid;
  conf_word_t conf;
  logic mem_req_valid;
  addr_t mem_req_addr;
  tag_t mem_req_tag;
  logic mem_ready;
  logic mem_rsp_valid;
  tag_t mem_rsp_tag;
  line_t mem_rsp_data;
  logic [1:0] user_available;
  logic [1:0] user_rd_req;
  logic [1:0] user_rd_valid;
  logic [1:0] done;
  line_t user_rd_data [2];
  logic [7:0] stall_pct;
  logic [7:0] stall_len;

  // Reference model state per queue.
  addr_t base [2];
  int cfg_lines [2];
  int total [2];
  int delivered [2];
  int granted [2];
  int popped [2];
  int received [2];
  int stored [2];
  logic [1:0] pop_d1;
  logic [1:0] pop_d2;
  logic no_req;
  logic have_last;
  tag_t last_tag;
  int errors = 0;
  int tests_failed = 0;
  int cycle_count = 0;
  int deadline = 1000;
  string test_name = "reset";

  function automatic line_t expected_line(input addr_t addr);
    return {addr ^ 32'hc3a5_5a3c, addr * 32'h9e37_79b1};
  endfunction

  task automatic report_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    errors++;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  fdam_input_subsystem #(
    .NUM_QUEUES(2),
    .FIFO_DEPTH_BITS(4)
  ) u_dut (
    .clk(clk),
    .rst_internal(rst_internal),
    .start(start),
    .conf_valid(conf_valid),
    .conf(conf),
    .mem_req_valid(mem_req_valid),
    .mem_req_addr(mem_req_addr),
    .mem_req_tag(mem_req_tag),
    .mem_ready(mem_ready),
    .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp_tag(mem_rsp_tag),
    .mem_rsp_data(mem_rsp_data),
    .user_available_0(user_available[0]),
    .user_rd_req_0(user_rd_req[0]),
    .user_rd_data_0(user_rd_data[0]),
    .user_rd_valid_0(user_rd_valid[0]),
    .done_0(done[0]),
    .user_available_1(user_available[1]),
    .user_rd_req_1(user_rd_req[1]),
    .user_rd_data_1(user_rd_data[1]),
    .user_rd_valid_1(user_rd_valid[1]),
    .done_1(done[1])
  );

  fdam_mem_model u_mem (
    .clk(clk),
    .rst_internal(rst_internal),
    .stall_pct(stall_pct),
    .stall_len(stall_len),
    .mem_req_valid(mem_req_valid),
    .mem_req_addr(mem_req_addr),
    .mem_req_tag(mem_req_tag),
    .mem_ready(mem_ready),
    .mem_rsp_valid(mem_rsp_valid),
    .mem_rsp_tag(mem_rsp_tag),
    .mem_rsp_data(mem_rsp_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Port monitor and checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin : monitor
    logic pop_now;
    int other;
    if (rst_internal) begin
      pop_d1 = '0;
      pop_d2 = '0;
      have_last = 1'b0;
    end else begin
      if (mem_req_valid && !mem_ready) begin
        report_error("request issued while mem_ready low");
      end
      if (mem_req_valid && no_req) begin
        report_error("request issued without a matching configuration");
      end
      if (mem_req_valid && mem_ready) begin
        other = (mem_req_tag == 0) ? 1 : 0;
        if (mem_req_tag > 1) begin
          report_error($sformatf("unknown request tag %0d", mem_req_tag));
        end else begin
          if (have_last && mem_req_tag == last_tag && u_dut.req_valid[other]) begin
            report_error($sformatf("tag %0d granted twice while queue %0d waits",
                                   mem_req_tag, other));
          end
          if (mem_req_addr != base[mem_req_tag] + addr_t'(granted[mem_req_tag])) begin
            report_error($sformatf("queue %0d request address %h", mem_req_tag,
                                   mem_req_addr));
          end
          granted[mem_req_tag] += BURST_LINES;
        end
        have_last = 1'b1;
        last_tag = mem_req_tag;
      end
      for (int q = 0; q < 2; q++) begin
        pop_now = user_rd_req[q] && user_available[q];
        // Beats land in the FIFO one cycle after they show on the bus.
        if (user_available[q] != (stored[q] > popped[q])) begin
          report_error($sformatf("queue %0d user_available %0b with %0d lines stored", q,
                                 user_available[q], stored[q] - popped[q]));
        end
        if (user_rd_valid[q] != pop_d2[q]) begin
          report_error($sformatf("queue %0d user_rd_valid not two cycles after pop", q));
        end
        if (user_rd_valid[q]) begin
          if (delivered[q] >= total[q]) begin
            report_error($sformatf("queue %0d delivered an extra line", q));
          end else if (user_rd_data[q] != expected_line(base[q] + addr_t'(delivered[q]))) begin
            report_error($sformatf("queue %0d line %0d data %h", q, delivered[q],
                                   user_rd_data[q]));
          end
          delivered[q]++;
        end
        if (done[q] && received[q] < cfg_lines[q]) begin
          report_error($sformatf("queue %0d done after %0d lines", q, received[q]));
        end
        if (granted[q] - popped[q] > FIFO_LINES) begin
          report_error($sformatf("queue %0d holds %0d lines", q, granted[q] - popped[q]));
        end
        if (pop_now) begin
          popped[q]++;
        end
        pop_d2[q] = pop_d1[q];
        pop_d1[q] = pop_now;
        stored[q] = received[q];
      end
      if (mem_rsp_valid && mem_rsp_tag < 2) begin
        received[mem_rsp_tag]++;
      end
    end
  end

  // Limit scales with the lines of the running test.
  always @(posedge clk) begin : watchdog
    cycle_count++;
    if (cycle_count > deadline) begin
      $display("Timeout: %s still running after cycle %0d", test_name, deadline);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic send_conf(input conf_type_t kind, input addr_t addr, input int lines,
                           input int id);
    @(negedge clk);
    conf_valid = kind;
    conf = {addr, qtd_t'(lines), tag_t'(id)};
    @(negedge clk);
    conf_valid = CONF_TYPE_NONE;
    conf = '0;
  endtask

  task automatic run_test(input string name, input int pop_pct, input int stall_p,
                          input int stall_l, input bit filter, input bit same_count);
    int err_start;
    int limit;
    err_start = errors;
    test_name = name;
    @(negedge clk);
    rst_internal = 1'b1;
    start = 1'b0;
    user_rd_req = '0;
    stall_pct = 8'(stall_p);
    stall_len = 8'(stall_l);
    no_req = filter;
    for (int q = 0; q < 2; q++) begin
      base[q] = $urandom();
      cfg_lines[q] = $urandom_range(48, 1);
      if (same_count && q == 1) begin
        cfg_lines[q] = cfg_lines[0];
      end
      total[q] = (cfg_lines[q] + BURST_LINES - 1) / BURST_LINES * BURST_LINES;
      delivered[q] = 0;
      granted[q] = 0;
      popped[q] = 0;
      received[q] = 0;
      stored[q] = 0;
    end
    limit = (total[0] + total[1]) * WORST_LATENCY * MARGIN;
    deadline = cycle_count + RESET_CYCLES + 40 + limit;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_internal = 1'b0;
    if (filter) begin
      // Idle type and foreign ids must be ignored.
      start = 1'b1;
      send_conf(CONF_TYPE_NONE, ~base[0], 8, 0);
      send_conf(CONF_TYPE_IN, ~base[1], 8, 2);
      send_conf(CONF_TYPE_IN, base[0] + 32'd64, 12, 255);
      repeat (20) @(negedge clk);
      no_req = 1'b0;
    end
    send_conf(CONF_TYPE_IN, base[0], cfg_lines[0], 0);
    send_conf(CONF_TYPE_IN, base[1], cfg_lines[1], 1);
    start = 1'b1;
    while (!(delivered[0] == total[0] && delivered[1] == total[1] && done == 2'b11)) begin
      @(negedge clk);
      for (int q = 0; q < 2; q++) begin
        user_rd_req[q] = ($urandom_range(99) < pop_pct);
      end
    end
    user_rd_req = '0;
    repeat (8) @(negedge clk);
    if (done != 2'b11) begin
      report_error("done dropped before reset");
    end
    start = 1'b0;
    if (errors == err_start) begin
      $display("%s: %0d lines checked, passed", name, delivered[0] + delivered[1]);
    end else begin
      $display("%s: %0d errors", name, errors - err_start);
      tests_failed++;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_internal = 1'b1;
    start = 1'b0;
    conf_valid = CONF_TYPE_NONE;
    conf = '0;
    user_rd_req = '0;
    stall_pct = '0;
    stall_len = 8'd1;
    no_req = 1'b0;
    run_test("streaming", 50, 10, 3, 1'b0, 1'b0);
    run_test("conf_filter", 50, 10, 3, 1'b1, 1'b0);
    run_test("mem_backpressure", 60, 40, 20, 1'b0, 1'b0);
    run_test("credit_limit", 6, 10, 3, 1'b0, 1'b0);
    run_test("completion_sharing", 90, 0, 1, 1'b0, 1'b1);
    $display("Summary: 5 tests, %0d failed, %0d errors", tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
source/fdam_pkg.sv
source/fdam_conf_receiver.sv
source/fdam_line_fifo.sv
source/fdam_input_queue_controller.sv
source/fdam_read_arbiter.sv
source/fdam_input_subsystem.sv
bench/fdam_mem_model.sv
bench/tb_fdam_input_subsystem.sv
